//--- hdl/zx_pkg.sv
// ==================================================
// ZX memory and I/O core shared definitions
// Widths, port numbers, fixed banks, beeper levels
// and machine model codes
// ==================================================

package zx_pkg;

	// ==================================================
	// Bus and data widths
	// ==================================================

	// Bank offset width, one 16K slot
	localparam int SLOT_BITS = 14;

	typedef logic [15:0] cpu_addr_t;
	// Bit 16 set selects I/O space
	typedef logic [16:0] wb_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  bank_t;
	// Bank number on top of the slot offset
	typedef logic [17:0] ram_addr_t;
	typedef logic [2:0]  border_t;
	typedef logic [15:0] sample_t;

	// ==================================================
	// Machine models
	// ==================================================

	typedef logic [1:0] machine_t;

	localparam machine_t MACHINE_128K     = 2'd0;
	localparam machine_t MACHINE_PENTAGON = 2'd1;
	localparam machine_t MACHINE_SCORPION = 2'd2;
	localparam machine_t MACHINE_48K      = 2'd3;

	// ==================================================
	// Ports, banks and levels
	// ==================================================

	// 7FFD decodes on A15 and A1 both low
	localparam cpu_addr_t PORT_7FFD_MASK = 16'h8002;
	// Scorpion extra paging port, full decode
	localparam cpu_addr_t PORT_1FFD = 16'h1FFD;

	// Banks wired to slots 1 and 2
	localparam bank_t BANK_SLOT1 = 4'd5;
	localparam bank_t BANK_SLOT2 = 4'd2;

	// Floating bus value
	localparam byte_t OPEN_BUS = 8'hFF;

	localparam sample_t EAR_WEIGHT = 16'h4000;
	localparam sample_t MIC_WEIGHT = 16'h2000;

endpackage

//--- hdl/zx_bus_slave.sv
// ==================================================
// Wishbone classic slave
// Turns each bus cycle into one memory or I/O
// request and returns the ack two edges later
// ==================================================

`timescale 1ns/1ns

module zx_bus_slave (
	input  logic             clk_sys,
	input  logic             reset,

	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  zx_pkg::wb_addr_t wb_adr,
	input  zx_pkg::byte_t    wb_dat_w,
	output zx_pkg::byte_t    wb_dat_r,
	output logic             wb_ack,

	input  zx_pkg::byte_t    ram_rdata,
	input  logic             slot_open,

	output logic             mem_req,
	output logic             io_req,
	output zx_pkg::cpu_addr_t bus_addr,
	output logic             bus_we,
	output zx_pkg::byte_t    bus_wdata
);

	// Access timer
	// 0 idle, 1 request strobe, 2 ack
	logic [1:0] timer;
	logic       accept;
	logic       io_space;
	// Read data comes from the floating bus
	logic       open_q;

	assign accept   = wb_cyc & wb_stb & (timer == 2'd0);
	assign io_space = wb_adr[16];

	// ==================================================
	// Cycle pacing
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			timer   <= 2'd0;
			wb_ack  <= 1'b0;
			mem_req <= 1'b0;
			io_req  <= 1'b0;
			open_q  <= 1'b0;
		end else begin
			mem_req <= accept & ~io_space;
			io_req  <= accept & io_space;
			wb_ack  <= (timer == 2'd1);

			if (accept) begin
				timer <= 2'd1;
			end else if (timer == 2'd2) begin
				// Master still holds stb on this edge, so stay out of idle until now
				timer <= 2'd0;
			end else if (timer != 2'd0) begin
				timer <= timer + 2'd1;
			end

			// Slot decode is only valid in the strobe cycle
			if (mem_req | io_req) begin
				open_q <= io_req | slot_open;
			end
		end
	end

	// Address and write data held for the request
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			bus_addr  <= wb_adr[15:0];
			bus_we    <= wb_we;
			bus_wdata <= wb_dat_w;
		end
	end

	// ==================================================
	// Read data
	// ==================================================

	assign wb_dat_r = open_q ? zx_pkg::OPEN_BUS : ram_rdata;

endmodule

//--- hdl/zx_pager.sv
// ==================================================
// Memory pager
// Holds the 7FFD and 1FFD paging state and maps
// the four 16K slots onto physical RAM banks
// ==================================================

`timescale 1ns/1ns

module zx_pager #(
	parameter int RAM_BANK_BITS = 4
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::machine_t  machine,

	input  logic              mem_req,
	input  logic              io_req,
	input  zx_pkg::cpu_addr_t bus_addr,
	input  logic              bus_we,
	input  zx_pkg::byte_t     bus_wdata,

	output zx_pkg::ram_addr_t ram_addr,
	output logic              ram_we,
	output logic              ram_en,
	output logic              slot_open,
	output logic              screen_shadow
);

	// With only 128K fitted the high bank bit never reaches the RAM
	localparam bit HIGH_BANK_EN = (RAM_BANK_BITS > 3);

	zx_pkg::machine_t model;
	zx_pkg::byte_t    page_reg;
	logic             page_high;
	logic             ram0;

	logic             is_scorpion;
	logic             is_pentagon;
	logic             page_lock;
	logic             port_7ffd;
	logic             port_1ffd;
	logic             page_wr;
	zx_pkg::bank_t    bank;

	assign is_scorpion = (model == zx_pkg::MACHINE_SCORPION);
	assign is_pentagon = (model == zx_pkg::MACHINE_PENTAGON);

	// 48K never pages; others lock once bit 5 is written
	assign page_lock = page_reg[5] | (model == zx_pkg::MACHINE_48K);

	// Scorpion also needs A14 high on 7FFD, which keeps 1FFD apart
	assign port_7ffd = ((bus_addr & zx_pkg::PORT_7FFD_MASK) == '0) &
		(bus_addr[14] | ~is_scorpion);
	assign port_1ffd = is_scorpion & (bus_addr == zx_pkg::PORT_1FFD);

	assign page_wr = io_req & bus_we & ~page_lock;

	// ==================================================
	// Paging registers
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model     <= machine;
			page_reg  <= '0;
			page_high <= 1'b0;
			ram0      <= 1'b0;
		end else if (page_wr) begin
			if (port_7ffd) begin
				page_reg <= bus_wdata;
				if (is_pentagon) begin
					page_high <= bus_wdata[6];
				end
			end
			if (port_1ffd) begin
				page_high <= bus_wdata[4];
				ram0      <= bus_wdata[0];
			end
		end
	end

	assign screen_shadow = page_reg[3];

	// ==================================================
	// Slot to bank translation
	// ==================================================

	always_comb begin
		slot_open = 1'b0;
		case (bus_addr[15:14])
			2'd0: begin
				// No ROM here, so slot 0 floats unless Scorpion RAM is paged in
				bank      = '0;
				slot_open = ~ram0;
			end
			2'd1: bank = zx_pkg::BANK_SLOT1;
			2'd2: bank = zx_pkg::BANK_SLOT2;
			default: bank = {page_high & HIGH_BANK_EN, page_reg[2:0]};
		endcase
	end

	assign ram_addr = {bank, bus_addr[zx_pkg::SLOT_BITS-1:0]};
	assign ram_en   = mem_req & ~slot_open;
	assign ram_we   = mem_req & bus_we & ~slot_open;

endmodule

//--- hdl/zx_ram.sv
// ==================================================
// Banked system RAM
// Single port, synchronous read, write first
// ==================================================

`timescale 1ns/1ns

module zx_ram #(
	parameter int RAM_BANK_BITS = 4
) (
	input  logic              clk_sys,
	input  logic              ram_en,
	input  logic              ram_we,
	input  zx_pkg::ram_addr_t ram_addr,
	input  zx_pkg::byte_t     bus_wdata,
	output zx_pkg::byte_t     ram_rdata
);

	localparam int ADDR_BITS = RAM_BANK_BITS + zx_pkg::SLOT_BITS;
	localparam int DEPTH     = 1 << ADDR_BITS;

	zx_pkg::byte_t          mem [0:DEPTH-1];
	logic [ADDR_BITS-1:0]   addr;

	// Bank bits above the fitted size are dropped
	assign addr = ram_addr[ADDR_BITS-1:0];

	always_ff @(posedge clk_sys) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[addr] <= bus_wdata;
				// New data shows on the read port in the same cycle
				ram_rdata <= bus_wdata;
			end else begin
				ram_rdata <= mem[addr];
			end
		end
	end

endmodule

//--- hdl/zx_ula_port.sv
// ==================================================
// ULA output port
// Latches border, MIC and EAR from even I/O writes
// and mixes EAR and MIC into the beeper sample
// ==================================================

`timescale 1ns/1ns

module zx_ula_port (
	input  logic              clk_sys,
	input  logic              reset,

	input  logic              io_req,
	input  zx_pkg::cpu_addr_t bus_addr,
	input  logic              bus_we,
	input  zx_pkg::byte_t     bus_wdata,

	output zx_pkg::border_t   border,
	output zx_pkg::sample_t   audio
);

	logic            ula_wr;
	logic            ear;
	logic            mic;
	zx_pkg::sample_t ear_level;
	zx_pkg::sample_t mic_level;

	// ULA answers any even port
	assign ula_wr = io_req & bus_we & ~bus_addr[0];

	// ==================================================
	// Port latch
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= '0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (ula_wr) begin
			border <= bus_wdata[2:0];
			mic    <= bus_wdata[3];
			ear    <= bus_wdata[4];
		end
	end

	// ==================================================
	// Beeper mix
	// ==================================================

	assign ear_level = ear ? zx_pkg::EAR_WEIGHT : '0;
	assign mic_level = mic ? zx_pkg::MIC_WEIGHT : '0;

	// Levels are small enough that the sum never wraps
	assign audio = ear_level + mic_level;

endmodule

//--- hdl/zx_memio.sv
// ==================================================
// ZX Spectrum memory and I/O core
// Wishbone slave in front of the pager, banked RAM
// and the ULA output port
// ==================================================

`timescale 1ns/1ns

module zx_memio #(
	parameter int RAM_BANK_BITS = 4
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  zx_pkg::machine_t machine,

	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  zx_pkg::wb_addr_t wb_adr,
	input  zx_pkg::byte_t    wb_dat_w,
	output zx_pkg::byte_t    wb_dat_r,
	output logic             wb_ack,

	output zx_pkg::border_t  border,
	output zx_pkg::sample_t  audio,
	output logic             screen_shadow
);

	logic              mem_req;
	logic              io_req;
	zx_pkg::cpu_addr_t bus_addr;
	logic              bus_we;
	zx_pkg::byte_t     bus_wdata;

	zx_pkg::ram_addr_t ram_addr;
	logic              ram_we;
	logic              ram_en;
	logic              slot_open;
	zx_pkg::byte_t     ram_rdata;

	// ==================================================
	// Bus side
	// ==================================================

	zx_bus_slave bus_slave (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.ram_rdata (ram_rdata),
		.slot_open (slot_open),
		.mem_req   (mem_req),
		.io_req    (io_req),
		.bus_addr  (bus_addr),
		.bus_we    (bus_we),
		.bus_wdata (bus_wdata)
	);

	// ==================================================
	// Memory
	// ==================================================

	zx_pager #(
		.RAM_BANK_BITS (RAM_BANK_BITS)
	) pager (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine       (machine),
		.mem_req       (mem_req),
		.io_req        (io_req),
		.bus_addr      (bus_addr),
		.bus_we        (bus_we),
		.bus_wdata     (bus_wdata),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.ram_en        (ram_en),
		.slot_open     (slot_open),
		.screen_shadow (screen_shadow)
	);

	zx_ram #(
		.RAM_BANK_BITS (RAM_BANK_BITS)
	) ram (
		.clk_sys   (clk_sys),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.bus_wdata (bus_wdata),
		.ram_rdata (ram_rdata)
	);

	// ==================================================
	// ULA output
	// ==================================================

	zx_ula_port ula_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_req    (io_req),
		.bus_addr  (bus_addr),
		.bus_we    (bus_we),
		.bus_wdata (bus_wdata),
		.border    (border),
		.audio     (audio)
	);

endmodule

//--- include/zx_tb_model.svh
// ==================================================
// Testbench reference model
// Paging state, 256K RAM image and ULA latch,
// plus the typed compare tasks
// ==================================================

`ifndef ZX_TB_MODEL_SVH
`define ZX_TB_MODEL_SVH

zx_pkg::machine_t ref_machine;
zx_pkg::byte_t    ref_page;
logic             ref_high;
logic             ref_ram0;
logic             ref_ear;
logic             ref_mic;
zx_pkg::border_t  ref_border;
// Full 256K image, bytes never written stay unknown
zx_pkg::byte_t    ref_mem [0:262143];

int check_count;
int error_count;

function automatic void reset_model(input zx_pkg::machine_t m);
	ref_machine = m;
	ref_page    = 8'h00;
	ref_high    = 1'b0;
	ref_ram0    = 1'b0;
	ref_ear     = 1'b0;
	ref_mic     = 1'b0;
	ref_border  = 3'd0;
endfunction

// Physical byte address, or -1 when the slot floats
function automatic int phys_addr(input zx_pkg::cpu_addr_t a);
	int bank;
	case (a[15:14])
		2'd0: bank = ref_ram0 ? 0 : -1;
		2'd1: bank = 5;
		2'd2: bank = 2;
		default: bank = (ref_high ? 8 : 0) + int'(ref_page[2:0]);
	endcase
	if (bank < 0) begin
		return -1;
	end
	return bank * 16384 + int'(a[13:0]);
endfunction

function automatic zx_pkg::byte_t mem_expect(input zx_pkg::cpu_addr_t a);
	int p;
	p = phys_addr(a);
	if (p < 0) begin
		return 8'hFF;
	end
	return ref_mem[p];
endfunction

function automatic void apply_mem_write(input zx_pkg::cpu_addr_t a, input zx_pkg::byte_t d);
	int p;
	p = phys_addr(a);
	if (p >= 0) begin
		ref_mem[p] = d;
	end
endfunction

function automatic void apply_io_write(input zx_pkg::cpu_addr_t a, input zx_pkg::byte_t d);
	logic locked;
	locked = ref_page[5] || (ref_machine == zx_pkg::MACHINE_48K);
	if (!locked) begin
		// 7FFD: A15 and A1 low, Scorpion also wants A14 high
		if (!a[15] && !a[1] && (ref_machine != zx_pkg::MACHINE_SCORPION || a[14])) begin
			ref_page = d;
			if (ref_machine == zx_pkg::MACHINE_PENTAGON) begin
				ref_high = d[6];
			end
		end
		if (ref_machine == zx_pkg::MACHINE_SCORPION && a == 16'h1FFD) begin
			ref_high = d[4];
			ref_ram0 = d[0];
		end
	end
	// ULA answers every even port
	if (!a[0]) begin
		ref_border = d[2:0];
		ref_mic    = d[3];
		ref_ear    = d[4];
	end
endfunction

function automatic zx_pkg::sample_t expected_audio();
	return (ref_ear ? 16'h4000 : 16'h0000) + (ref_mic ? 16'h2000 : 16'h0000);
endfunction

// ==================================================
// Compare tasks
// ==================================================

task automatic compare_byte(input string name, input zx_pkg::byte_t expected,
		input zx_pkg::byte_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("mismatch %s: expected %h, actual %h", name, expected, actual);
	end
endtask

task automatic check_border(input string name, input zx_pkg::border_t expected,
		input zx_pkg::border_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("mismatch %s border: expected %0d, actual %0d", name, expected, actual);
	end
endtask

task automatic verify_sample(input string name, input zx_pkg::sample_t expected,
		input zx_pkg::sample_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("mismatch %s audio: expected %h, actual %h", name, expected, actual);
	end
endtask

task automatic confirm_shadow(input string name, input logic expected, input logic actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("mismatch %s shadow: expected %b, actual %b", name, expected, actual);
	end
endtask

`endif

//--- verification/zx_memio_tb.sv
// ==================================================
// Memory and I/O core testbench
// Random Wishbone traffic checked against a model
// ==================================================

`timescale 1ns/1ns

module zx_memio_tb;

	// Bus cycles issued by each test, four clocks apiece
	localparam int CYCLES_BASIC  = 128;
	localparam int CYCLES_PAGING = 80;
	localparam int CYCLES_LOCK   = 36;
	localparam int CYCLES_HIGH   = 146;
	localparam int CYCLES_ULA    = 64;
	localparam int RESET_CYCLES  = 9 * 2;
	localparam int RUN_LIMIT     = (CYCLES_BASIC + CYCLES_PAGING + CYCLES_LOCK + CYCLES_HIGH +
		CYCLES_ULA) * 4 + RESET_CYCLES + 200;

	logic              clk_sys;
	logic              reset;
	zx_pkg::machine_t  machine;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	zx_pkg::wb_addr_t  wb_adr;
	zx_pkg::byte_t     wb_dat_w;
	zx_pkg::byte_t     wb_dat_r;
	logic              wb_ack;
	zx_pkg::border_t   border;
	zx_pkg::sample_t   audio;
	logic              screen_shadow;

	logic [31:0] rng_state;
	string       cur_test;
	int          tests_passed;
	int          tests_failed;

	`include "zx_tb_model.svh"

	zx_memio #(
		.RAM_BANK_BITS (4)
	) uut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine       (machine),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.border        (border),
		.audio         (audio),
		.screen_shadow (screen_shadow)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin : timeout_watch
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < RUN_LIMIT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d clock cycles", RUN_LIMIT);
		$display("Something failed");
		$finish;
	end

	// ==================================================
	// Random numbers and bus helpers
	// ==================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Entered and left 1 ns after a rising edge
	task automatic apply_reset(input zx_pkg::machine_t m);
		machine = m;
		reset   = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		reset_model(m);
	endtask

	task automatic bus_cycle(input zx_pkg::wb_addr_t adr, input logic we,
			input zx_pkg::byte_t wdata, output zx_pkg::byte_t rdata);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
			@(negedge clk_sys);
		end while (wb_ack !== 1'b1 && n < 8);
		if (wb_ack !== 1'b1) begin
			error_count++;
			$display("%s: no acknowledge within 8 clock edges", cur_test);
		end else if (n != 2) begin
			error_count++;
			$display("%s: acknowledge came %0d edges after acceptance instead of 2", cur_test, n);
		end
		rdata = wb_dat_r;
		@(posedge clk_sys);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk_sys);
		if (wb_ack !== 1'b0) begin
			error_count++;
			$display("%s: acknowledge held high for more than one cycle", cur_test);
		end
		@(posedge clk_sys);
		#1;
	endtask

	task automatic mem_write(input zx_pkg::cpu_addr_t a, input zx_pkg::byte_t d);
		zx_pkg::byte_t unused;
		bus_cycle({1'b0, a}, 1'b1, d, unused);
		apply_mem_write(a, d);
	endtask

	task automatic mem_check(input zx_pkg::cpu_addr_t a);
		zx_pkg::byte_t got;
		bus_cycle({1'b0, a}, 1'b0, 8'h00, got);
		compare_byte($sformatf("%s @%h", cur_test, a), mem_expect(a), got);
	endtask

	task automatic io_write(input zx_pkg::cpu_addr_t a, input zx_pkg::byte_t d);
		zx_pkg::byte_t unused;
		bus_cycle({1'b1, a}, 1'b1, d, unused);
		apply_io_write(a, d);
	endtask

	task automatic io_check(input zx_pkg::cpu_addr_t a);
		zx_pkg::byte_t got;
		bus_cycle({1'b1, a}, 1'b0, 8'h00, got);
		compare_byte($sformatf("%s io %h", cur_test, a), 8'hFF, got);
	endtask

	task automatic finish_test(input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("%s: pass", cur_test);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d errors", cur_test, error_count - errors_before);
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic run_basic();
		int errors_before;
		logic [31:0] r;
		zx_pkg::cpu_addr_t a;
		zx_pkg::cpu_addr_t addrs[$];
		errors_before = error_count;
		cur_test = "basic_128k";
		apply_reset(zx_pkg::MACHINE_128K);
		for (int i = 0; i < 48; i++) begin
			r = next_random();
			a = {(r[16] ? 2'd2 : 2'd1), r[13:0]};
			mem_write(a, r[31:24]);
			addrs.push_back(a);
		end
		foreach (addrs[k]) begin
			mem_check(addrs[k]);
		end
		// Page 0 sits in slot 3 after reset, so slot 0 writes must not reach it
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			a = {2'd0, r[13:0]};
			mem_write(16'hC000 | a, r[23:16]);
			mem_write(a, r[31:24]);
			mem_check(a);
			mem_check(16'hC000 | a);
		end
		finish_test(errors_before);
	endtask

	task automatic run_paging();
		int errors_before;
		logic [31:0] r;
		logic [31:0] r2;
		zx_pkg::byte_t d;
		logic [13:0] offs [0:7];
		errors_before = error_count;
		cur_test = "paging_7ffd";
		apply_reset(zx_pkg::MACHINE_128K);
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			r2 = next_random();
			d = r[7:0] & 8'hDF;
			if (i < 8) begin
				d[2:0] = i[2:0];
				offs[i] = r2[13:0];
			end
			io_write(r[31:16] & 16'h7FFD, d);
			confirm_shadow(cur_test, ref_page[3], screen_shadow);
			mem_write({2'b11, r2[13:0]}, r2[31:24]);
			mem_check({2'b11, r2[13:0]});
			if (ref_page[2:0] == 3'd5) begin
				mem_check({2'b01, r2[13:0]});
			end else if (ref_page[2:0] == 3'd2) begin
				mem_check({2'b10, r2[13:0]});
			end
		end
		for (int k = 0; k < 8; k++) begin
			io_write(16'h7FFD, k[7:0]);
			mem_check({2'b11, offs[k]});
		end
		finish_test(errors_before);
	endtask

	task automatic run_lock();
		int errors_before;
		logic [31:0] r;
		errors_before = error_count;
		cur_test = "lock_bit";
		apply_reset(zx_pkg::MACHINE_128K);
		r = next_random();
		io_write(16'h7FFD, (r[15:8] & 8'h1F) | 8'h20);
		confirm_shadow(cur_test, ref_page[3], screen_shadow);
		mem_write(16'hC100, r[7:0]);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			io_write(16'h7FFD, r[7:0]);
			confirm_shadow(cur_test, ref_page[3], screen_shadow);
			mem_check(16'hC100);
		end
		// 48K never pages
		apply_reset(zx_pkg::MACHINE_48K);
		r = next_random();
		mem_write(16'hC200, r[7:0]);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			io_write(16'h7FFD, r[7:0]);
			confirm_shadow(cur_test, 1'b0, screen_shadow);
			mem_check(16'hC200);
		end
		// Reset clears the lock
		apply_reset(zx_pkg::MACHINE_128K);
		io_write(16'h7FFD, 8'h08);
		confirm_shadow(cur_test, 1'b1, screen_shadow);
		finish_test(errors_before);
	endtask

	task automatic run_high_banks();
		int errors_before;
		logic [31:0] r;
		logic [31:0] r2;
		zx_pkg::cpu_addr_t a;
		zx_pkg::byte_t d;
		errors_before = error_count;
		cur_test = "high_banks";
		apply_reset(zx_pkg::MACHINE_PENTAGON);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			r2 = next_random();
			a = {2'b11, r[16:3]};
			d = {r[23], 2'b00, r[20:19], r[2:0]};
			io_write(16'h7FFD, d);
			mem_write(a, r[31:24]);
			io_write(16'h7FFD, d | 8'h40);
			mem_write(a, r2[7:0]);
			mem_check(a);
			io_write(16'h7FFD, d);
			mem_check(a);
		end
		apply_reset(zx_pkg::MACHINE_SCORPION);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			r2 = next_random();
			a = {2'b11, r[16:3]};
			io_write(16'h7FFD, {r[23:22], 1'b0, r[20:19], r[2:0]});
			io_write(16'h1FFD, 8'h00);
			mem_write(a, r[31:24]);
			io_write(16'h1FFD, 8'h10);
			mem_write(a, r2[7:0]);
			mem_check(a);
			io_write(16'h1FFD, 8'h00);
			mem_check(a);
		end
		// RAM at 0000 shares bank 0 with slot 3 on page 0
		io_write(16'h1FFD, 8'h01);
		io_write(16'h7FFD, 8'h00);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			a = {2'b00, r[13:0]};
			mem_write(a, r[31:24]);
			mem_check(a);
			mem_check(16'hC000 | a);
		end
		finish_test(errors_before);
	endtask

	task automatic run_ula();
		int errors_before;
		logic [31:0] r;
		zx_pkg::cpu_addr_t a;
		errors_before = error_count;
		cur_test = "ula_port";
		apply_reset(zx_pkg::MACHINE_128K);
		check_border(cur_test, ref_border, border);
		verify_sample(cur_test, expected_audio(), audio);
		for (int i = 0; i < 32; i++) begin
			r = next_random();
			a = {r[31:17], i[0]};
			io_write(a, r[7:0]);
			check_border(cur_test, ref_border, border);
			verify_sample(cur_test, expected_audio(), audio);
			io_check({r[15:8], r[23:16]});
		end
		finish_test(errors_before);
	endtask

	initial begin
		reset        = 1'b1;
		machine      = zx_pkg::MACHINE_128K;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		rng_state    = 32'h5abd_1387;
		check_count  = 0;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		@(posedge clk_sys);
		#1;

		run_basic();
		run_paging();
		run_lock();
		run_high_banks();
		run_ula();

		$display("%0d tests passed, %0d failed, %0d checks, %0d errors",
			tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- zx_memio.f
+incdir+include
hdl/zx_pkg.sv
hdl/zx_bus_slave.sv
hdl/zx_pager.sv
hdl/zx_ram.sv
hdl/zx_ula_port.sv
hdl/zx_memio.sv
verification/zx_memio_tb.sv

//--- Bender.yml
package:
  name: zx_memio

sources:
  - files:
      - hdl/zx_pkg.sv
      - hdl/zx_bus_slave.sv
      - hdl/zx_pager.sv
      - hdl/zx_ram.sv
      - hdl/zx_ula_port.sv
      - hdl/zx_memio.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/zx_memio_tb.sv
